// ==== rtl/mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Primary opcodes
`define OP_RTYPE  6'h00
`define OP_J      6'h02
`define OP_BEQ    6'h04
`define OP_BNE    6'h05
`define OP_ADDIU  6'h09
`define OP_ORI    6'h0d
`define OP_LUI    6'h0f
`define OP_LW     6'h23
`define OP_SW     6'h2b

// Function codes for R-type
`define FN_ADDU   6'h21
`define FN_SUBU   6'h23
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_XOR    6'h26
`define FN_SLT    6'h2a

`define RESET_PC  32'h0000_0000
`define REG_COUNT 32

`endif

// ==== rtl/mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;     // Data or address word
    typedef logic [4:0]  reg_addr_t; // Register index
    typedef logic [15:0] imm_t;      // Raw immediate field

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

endpackage

// ==== rtl/mips_fetch.sv ====
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_fetch
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  taken_i,
    input  word_t target_i,
    output word_t imem_addr_o,
    input  word_t imem_data_i,
    output word_t id_inst_o,
    output word_t id_pc_o
);

    word_t pc_q;

    assign imem_addr_o = pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `RESET_PC;
        end else if (taken_i) begin
            pc_q <= target_i; // Delay slot is already being fetched
        end else begin
            pc_q <= pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_inst_o <= '0; // NOP
            id_pc_o   <= `RESET_PC;
        end else begin
            id_inst_o <= imem_data_i;
            id_pc_o   <= pc_q;
        end
    end

endmodule

// ==== rtl/mips_regfile.sv ====
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_regfile
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle write is returned to the reader
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

// ==== rtl/mips_decode.sv ====
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_decode
    import mips_pkg::*;
(
    input  word_t     inst_i,
    input  word_t     pc_i,
    output reg_addr_t rs_addr_o,
    output reg_addr_t rt_addr_o,
    input  word_t     rs_data_i,
    input  word_t     rt_data_i,
    input  reg_addr_t ex_dst_i,
    input  word_t     ex_result_i,
    input  mem_op_e   ex_mem_op_i,
    input  logic      mm_we_i,
    input  reg_addr_t mm_dst_i,
    input  word_t     mm_result_i,
    output logic      taken_o,
    output word_t     target_o,
    output alu_op_e   alu_op_o,
    output mem_op_e   mem_op_o,
    output logic      use_imm_o,
    output word_t     imm_o,
    output reg_addr_t dst_o,
    output logic      we_o,
    output word_t     op_a_o,
    output word_t     op_b_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    imm_t        imm;
    logic [25:0] jidx;

    reg_addr_t   dst;
    logic        wr_en;
    logic        is_beq;
    logic        is_bne;
    logic        is_j;
    word_t       pc_plus4;
    word_t       br_offset;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign funct  = inst_i[5:0];
    assign imm    = inst_i[15:0];
    assign jidx   = inst_i[25:0];

    assign rs_addr_o = rs;
    assign rt_addr_o = rt;

    always_comb begin
        alu_op_o  = ALU_ADD;
        mem_op_o  = MEM_NONE;
        use_imm_o = 1'b0;
        imm_o     = {{16{imm[15]}}, imm};
        wr_en     = 1'b0;
        dst       = rt;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                dst   = rd;
                wr_en = 1'b1;
                case (funct)
                    `FN_ADDU: alu_op_o = ALU_ADD;
                    `FN_SUBU: alu_op_o = ALU_SUB;
                    `FN_AND:  alu_op_o = ALU_AND;
                    `FN_OR:   alu_op_o = ALU_OR;
                    `FN_XOR:  alu_op_o = ALU_XOR;
                    `FN_SLT:  alu_op_o = ALU_SLT;
                    default:  wr_en    = 1'b0; // NOP and unsupported functs
                endcase
            end
            `OP_ADDIU: begin
                use_imm_o = 1'b1;
                wr_en     = 1'b1;
            end
            `OP_ORI: begin
                alu_op_o  = ALU_OR;
                use_imm_o = 1'b1;
                imm_o     = {16'h0000, imm}; // Zero-extended
                wr_en     = 1'b1;
            end
            `OP_LUI: begin
                alu_op_o  = ALU_LUI;
                use_imm_o = 1'b1;
                imm_o     = {16'h0000, imm};
                wr_en     = 1'b1;
            end
            `OP_LW: begin
                mem_op_o  = MEM_LOAD;
                use_imm_o = 1'b1;
                wr_en     = 1'b1;
            end
            `OP_SW: begin
                mem_op_o  = MEM_STORE;
                use_imm_o = 1'b1;
            end
            `OP_BEQ: is_beq = 1'b1;
            `OP_BNE: is_bne = 1'b1;
            `OP_J:   is_j   = 1'b1;
            default: ;
        endcase
    end

    // Non-writing instructions carry r0 so they never match a forward
    assign we_o  = wr_en;
    assign dst_o = wr_en ? dst : '0;

    function automatic word_t fwd_operand(input reg_addr_t addr, input word_t rf_data);
        word_t value;
        value = rf_data;
        if (addr != '0 && mm_we_i && addr == mm_dst_i) begin
            value = mm_result_i;
        end
        if (addr != '0 && addr == ex_dst_i && ex_mem_op_i != MEM_LOAD) begin
            value = ex_result_i; // Youngest result wins
        end
        return value;
    endfunction

    always_comb begin
        op_a_o = fwd_operand(rs, rs_data_i);
        op_b_o = fwd_operand(rt, rt_data_i);
    end

    assign pc_plus4  = pc_i + 32'd4;
    assign br_offset = {{14{imm[15]}}, imm, 2'b00};

    assign taken_o  = is_j
                    | (is_beq && op_a_o == op_b_o)
                    | (is_bne && op_a_o != op_b_o);
    assign target_o = is_j ? {pc_plus4[31:28], jidx, 2'b00} : pc_plus4 + br_offset;

endmodule

// ==== rtl/mips_execute.sv ====
`timescale 1ns/1ps

module mips_execute
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  alu_op_e   alu_op_i,
    input  mem_op_e   mem_op_i,
    input  logic      use_imm_i,
    input  word_t     imm_i,
    input  reg_addr_t dst_i,
    input  logic      we_i,
    input  word_t     op_a_i,
    input  word_t     op_b_i,
    output word_t     result_o,
    output word_t     store_data_o,
    output reg_addr_t dst_o,
    output logic      we_o,
    output mem_op_e   mem_op_o
);

    alu_op_e alu_op_q;
    mem_op_e mem_op_q;
    logic    use_imm_q;
    word_t   imm_q;
    reg_addr_t dst_q;
    logic    we_q;
    word_t   op_a_q;
    word_t   op_b_q;
    word_t   alu_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_op_q  <= ALU_ADD;
            mem_op_q  <= MEM_NONE;
            use_imm_q <= 1'b0;
            imm_q     <= '0;
            dst_q     <= '0;
            we_q      <= 1'b0;
            op_a_q    <= '0;
            op_b_q    <= '0;
        end else begin
            alu_op_q  <= alu_op_i;
            mem_op_q  <= mem_op_i;
            use_imm_q <= use_imm_i;
            imm_q     <= imm_i;
            dst_q     <= dst_i;
            we_q      <= we_i;
            op_a_q    <= op_a_i;
            op_b_q    <= op_b_i;
        end
    end

    assign alu_b = use_imm_q ? imm_q : op_b_q;

    always_comb begin
        case (alu_op_q)
            ALU_ADD: result_o = op_a_q + alu_b; // Also the load/store address
            ALU_SUB: result_o = op_a_q - alu_b;
            ALU_AND: result_o = op_a_q & alu_b;
            ALU_OR:  result_o = op_a_q | alu_b;
            ALU_XOR: result_o = op_a_q ^ alu_b;
            ALU_SLT: result_o = {31'b0, $signed(op_a_q) < $signed(alu_b)};
            ALU_LUI: result_o = {alu_b[15:0], 16'h0000};
            default: result_o = '0;
        endcase
    end

    assign store_data_o = op_b_q;
    assign dst_o        = dst_q;
    assign we_o         = we_q;
    assign mem_op_o     = mem_op_q;

endmodule

// ==== rtl/mips_memwb.sv ====
`timescale 1ns/1ps

module mips_memwb
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     ex_result_i,
    input  word_t     ex_store_data_i,
    input  reg_addr_t ex_dst_i,
    input  logic      ex_we_i,
    input  mem_op_e   ex_mem_op_i,
    output word_t     dmem_addr_o,
    output logic      dmem_rd_o,
    output logic      dmem_wr_o,
    output word_t     dmem_wdata_o,
    input  word_t     dmem_rdata_i,
    output logic      mm_we_o,
    output reg_addr_t mm_dst_o,
    output word_t     mm_result_o,
    output logic      wb_we_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    word_t     mm_result_q;
    word_t     mm_store_q;
    reg_addr_t mm_dst_q;
    logic      mm_we_q;
    mem_op_e   mm_mem_op_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mm_result_q <= '0;
            mm_store_q  <= '0;
            mm_dst_q    <= '0;
            mm_we_q     <= 1'b0;
            mm_mem_op_q <= MEM_NONE;
        end else begin
            mm_result_q <= ex_result_i;
            mm_store_q  <= ex_store_data_i;
            mm_dst_q    <= ex_dst_i;
            mm_we_q     <= ex_we_i;
            mm_mem_op_q <= ex_mem_op_i;
        end
    end

    assign dmem_addr_o  = mm_result_q;
    assign dmem_rd_o    = (mm_mem_op_q == MEM_LOAD);
    assign dmem_wr_o    = (mm_mem_op_q == MEM_STORE);
    assign dmem_wdata_o = mm_store_q;

    assign mm_we_o     = mm_we_q;
    assign mm_dst_o    = mm_dst_q;
    assign mm_result_o = dmem_rd_o ? dmem_rdata_i : mm_result_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we_o   <= 1'b0;
            wb_addr_o <= '0;
            wb_data_o <= '0;
        end else begin
            wb_we_o   <= mm_we_q && (mm_dst_q != '0); // r0 is never reported
            wb_addr_o <= mm_dst_q;
            wb_data_o <= mm_result_o;
        end
    end

endmodule

// ==== rtl/mips_core.sv ====
`timescale 1ns/1ps

module mips_core
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    output word_t     imem_addr_o,
    input  word_t     imem_data_i,
    output word_t     dmem_addr_o,
    output logic      dmem_rd_o,
    output logic      dmem_wr_o,
    output word_t     dmem_wdata_o,
    input  word_t     dmem_rdata_i,
    output logic      wb_we_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    logic      id_taken;
    word_t     id_target;
    word_t     id_inst;
    word_t     id_pc;
    reg_addr_t id_rs_addr;
    reg_addr_t id_rt_addr;
    word_t     id_rs_data;
    word_t     id_rt_data;
    alu_op_e   id_alu_op;
    mem_op_e   id_mem_op;
    logic      id_use_imm;
    word_t     id_imm;
    reg_addr_t id_dst;
    logic      id_we;
    word_t     id_op_a;
    word_t     id_op_b;

    word_t     ex_result;
    word_t     ex_store_data;
    reg_addr_t ex_dst;
    logic      ex_we;
    mem_op_e   ex_mem_op;

    logic      mm_we;
    reg_addr_t mm_dst;
    word_t     mm_result;

    mips_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .taken_i     (id_taken),
        .target_i    (id_target),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .id_inst_o   (id_inst),
        .id_pc_o     (id_pc)
    );

    mips_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .raddr1_i (id_rs_addr),
        .raddr2_i (id_rt_addr),
        .rdata1_o (id_rs_data),
        .rdata2_o (id_rt_data),
        .we_i     (wb_we_o),
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o)
    );

    mips_decode u_decode (
        .inst_i      (id_inst),
        .pc_i        (id_pc),
        .rs_addr_o   (id_rs_addr),
        .rt_addr_o   (id_rt_addr),
        .rs_data_i   (id_rs_data),
        .rt_data_i   (id_rt_data),
        .ex_dst_i    (ex_dst),
        .ex_result_i (ex_result),
        .ex_mem_op_i (ex_mem_op),
        .mm_we_i     (mm_we),
        .mm_dst_i    (mm_dst),
        .mm_result_i (mm_result),
        .taken_o     (id_taken),
        .target_o    (id_target),
        .alu_op_o    (id_alu_op),
        .mem_op_o    (id_mem_op),
        .use_imm_o   (id_use_imm),
        .imm_o       (id_imm),
        .dst_o       (id_dst),
        .we_o        (id_we),
        .op_a_o      (id_op_a),
        .op_b_o      (id_op_b)
    );

    mips_execute u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .alu_op_i     (id_alu_op),
        .mem_op_i     (id_mem_op),
        .use_imm_i    (id_use_imm),
        .imm_i        (id_imm),
        .dst_i        (id_dst),
        .we_i         (id_we),
        .op_a_i       (id_op_a),
        .op_b_i       (id_op_b),
        .result_o     (ex_result),
        .store_data_o (ex_store_data),
        .dst_o        (ex_dst),
        .we_o         (ex_we),
        .mem_op_o     (ex_mem_op)
    );

    mips_memwb u_memwb (
        .clk             (clk),
        .rst_n           (rst_n),
        .ex_result_i     (ex_result),
        .ex_store_data_i (ex_store_data),
        .ex_dst_i        (ex_dst),
        .ex_we_i         (ex_we),
        .ex_mem_op_i     (ex_mem_op),
        .dmem_addr_o     (dmem_addr_o),
        .dmem_rd_o       (dmem_rd_o),
        .dmem_wr_o       (dmem_wr_o),
        .dmem_wdata_o    (dmem_wdata_o),
        .dmem_rdata_i    (dmem_rdata_i),
        .mm_we_o         (mm_we),
        .mm_dst_o        (mm_dst),
        .mm_result_o     (mm_result),
        .wb_we_o         (wb_we_o),
        .wb_addr_o       (wb_addr_o),
        .wb_data_o       (wb_data_o)
    );

endmodule

// ==== test/tb_mips_model.svh ====
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

`include "mips_params.svh"

localparam int PROG_LEN   = 200;
localparam int DMEM_WORDS = 64;

word_t     prog [PROG_LEN];
word_t     init_dmem [DMEM_WORDS];
reg_addr_t exp_wr_addr [$];
word_t     exp_wr_data [$];
word_t     exp_st_addr [$];
word_t     exp_st_data [$];
word_t     exp_ld_addr [$];

function automatic word_t enc_r(logic [5:0] funct, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
    return {`OP_RTYPE, rs, rt, rd, 5'd0, funct};
endfunction

function automatic word_t enc_i(logic [5:0] op, reg_addr_t rs, reg_addr_t rt, imm_t imm);
    return {op, rs, rt, imm};
endfunction

// Picks a source in r1..r7 that avoids the preceding load's destination
function automatic reg_addr_t pick_src(reg_addr_t avoid);
    reg_addr_t r;
    r = reg_addr_t'($urandom_range(1, 7));
    if (r == avoid) begin
        r = (r == 5'd7) ? 5'd1 : r + 5'd1;
    end
    return r;
endfunction

task automatic build_program();
    logic [5:0]  fns [6];
    int unsigned pick;
    int unsigned skip;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    reg_addr_t   load_dst;
    logic        in_slot;
    imm_t        imm;
    fns      = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_SLT};
    load_dst = '0;
    in_slot  = 1'b0;
    for (int i = 0; i < PROG_LEN; i++) begin
        pick = $urandom_range(0, 15);
        if (in_slot && (pick inside {9, 10, 12, 13, 14})) begin
            pick = 6; // No branch or load in a delay slot
        end
        rs       = pick_src(load_dst);
        rt       = pick_src(load_dst);
        rd       = reg_addr_t'($urandom_range(1, 7));
        imm      = imm_t'($urandom);
        skip     = $urandom_range(1, 8);
        load_dst = '0;
        in_slot  = 1'b0;
        case (pick)
            6:  prog[i] = enc_i(`OP_ADDIU, rs, rd, imm);
            7:  prog[i] = enc_i(`OP_ORI, rs, rd, imm);
            8:  prog[i] = enc_i(`OP_LUI, '0, rd, imm);
            9, 10: begin
                prog[i]  = enc_i(`OP_LW, '0, rd, imm_t'($urandom_range(0, 63) * 4));
                load_dst = rd;
            end
            11: prog[i] = enc_i(`OP_SW, '0, rt, imm_t'($urandom_range(0, 63) * 4));
            12: begin
                prog[i] = enc_i(`OP_BEQ, rs, rt, imm_t'(skip));
                in_slot = 1'b1;
            end
            13: begin
                prog[i] = enc_i(`OP_BNE, rs, rt, imm_t'(skip));
                in_slot = 1'b1;
            end
            14: begin
                prog[i] = {`OP_J, 26'(i + 1 + skip)}; // Word index of the target
                in_slot = 1'b1;
            end
            default: prog[i] = enc_r(fns[pick % 6], rs, rt, rd);
        endcase
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
        init_dmem[i] = $urandom;
    end
endtask

// Instruction-level run with one delay slot after every branch and jump
task automatic run_model();
    word_t      regs [32];
    word_t      mem [DMEM_WORDS];
    word_t      inst;
    word_t      pc;
    word_t      npc;
    word_t      next;
    word_t      a;
    word_t      b;
    word_t      simm;
    word_t      addr;
    word_t      res;
    reg_addr_t  dst;
    logic       wr;
    regs = '{default: '0};
    mem  = init_dmem;
    pc   = `RESET_PC;
    npc  = pc + 4;
    while (pc < 32'(PROG_LEN * 4)) begin
        inst = prog[pc[9:2]];
        a    = regs[inst[25:21]];
        b    = regs[inst[20:16]];
        simm = {{16{inst[15]}}, inst[15:0]};
        addr = a + simm;
        next = npc + 4;
        dst  = inst[20:16];
        wr   = 1'b1;
        res  = '0;
        case (inst[31:26])
            `OP_RTYPE: begin
                dst = inst[15:11];
                case (inst[5:0])
                    `FN_ADDU: res = a + b;
                    `FN_SUBU: res = a - b;
                    `FN_AND:  res = a & b;
                    `FN_OR:   res = a | b;
                    `FN_XOR:  res = a ^ b;
                    `FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:  wr  = 1'b0;
                endcase
            end
            `OP_ADDIU: res = a + simm;
            `OP_ORI:   res = a | {16'h0000, inst[15:0]};
            `OP_LUI:   res = {inst[15:0], 16'h0000};
            `OP_LW: begin
                res = mem[addr[7:2]];
                exp_ld_addr.push_back(addr);
            end
            `OP_SW: begin
                wr = 1'b0;
                mem[addr[7:2]] = b;
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(b);
            end
            `OP_BEQ: begin
                wr = 1'b0;
                if (a == b) next = pc + 4 + (simm << 2);
            end
            `OP_BNE: begin
                wr = 1'b0;
                if (a != b) next = pc + 4 + (simm << 2);
            end
            `OP_J: begin
                wr   = 1'b0;
                next = {npc[31:28], inst[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != '0) begin
            regs[dst] = res;
            exp_wr_addr.push_back(dst);
            exp_wr_data.push_back(res);
        end
        pc  = npc;
        npc = next;
    end
endtask

`endif

// ==== test/tb_mips.sv ====
`timescale 1ns/1ps

module tb_mips
    import mips_pkg::*;
();

    `include "tb_mips_model.svh"

    localparam int RUN_LIMIT = 5000; // Cycles allowed for the whole program

    logic      clk;
    logic      rst_n;
    word_t     imem_addr;
    word_t     imem_data;
    word_t     dmem_addr;
    logic      dmem_rd;
    logic      dmem_wr;
    word_t     dmem_wdata;
    word_t     dmem_rdata;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;

    word_t     dmem [DMEM_WORDS];
    int        wr_idx = 0;
    int        st_idx = 0;
    int        ld_idx = 0;

    mips_core u_mips_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_addr_o  (dmem_addr),
        .dmem_rd_o    (dmem_rd),
        .dmem_wr_o    (dmem_wr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_rdata_i (dmem_rdata),
        .wb_we_o      (wb_we),
        .wb_addr_o    (wb_addr),
        .wb_data_o    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign imem_data  = (imem_addr < 32'(PROG_LEN * 4)) ?
                        prog[imem_addr[9:2]] : '0; // NOP past end
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (!rst_n) begin
            dmem <= init_dmem; // Same contents the model started from
        end else if (dmem_wr) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    task automatic end_with_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string why);
        $display("%s", why);
        end_with_failure();
    endtask

    task automatic check_eq(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    // Mid-cycle sampling of the write-back port and the data-memory strobes
    always @(negedge clk) begin
        if (!rst_n) begin
            check_eq("wb_we_o", word_t'(wb_we), '0);
            check_eq("dmem_wr_o", word_t'(dmem_wr), '0);
            check_eq("dmem_rd_o", word_t'(dmem_rd), '0);
        end else begin
            if (wb_we) begin
                if (wb_addr == '0) begin
                    report_problem("Register 0 was reported as written");
                end else if (wr_idx >= exp_wr_addr.size()) begin
                    report_problem("A register write appeared after all expected writes");
                end else begin
                    check_eq("wb_addr_o", word_t'(wb_addr), word_t'(exp_wr_addr[wr_idx]));
                    check_eq("wb_data_o", wb_data, exp_wr_data[wr_idx]);
                    wr_idx = wr_idx + 1;
                end
            end
            if (dmem_wr) begin
                if (st_idx >= exp_st_addr.size()) begin
                    report_problem("A store appeared after all expected stores");
                end else begin
                    check_eq("dmem_addr_o", dmem_addr, exp_st_addr[st_idx]);
                    check_eq("dmem_wdata_o", dmem_wdata, exp_st_data[st_idx]);
                    st_idx = st_idx + 1;
                end
            end
            if (dmem_rd) begin
                if (ld_idx >= exp_ld_addr.size()) begin
                    report_problem("A load appeared after all expected loads");
                end else begin
                    check_eq("dmem_addr_o", dmem_addr, exp_ld_addr[ld_idx]);
                    ld_idx = ld_idx + 1;
                end
            end
        end
    end

    initial begin
        int cycles;
        rst_n = 1'b0;
        void'($urandom(28));
        build_program();
        run_model();
        $display("Expecting %0d register writes, %0d loads and %0d stores",
                 exp_wr_addr.size(), exp_ld_addr.size(), exp_st_addr.size());
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        cycles = 0;
        while (wr_idx < exp_wr_addr.size() || st_idx < exp_st_addr.size() ||
               ld_idx < exp_ld_addr.size()) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > RUN_LIMIT) begin
                report_problem("Timed out before all expected writes, loads and stores were seen");
            end
        end

        repeat (20) @(posedge clk); // Monitor flags any extra write, load or store
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+rtl
+incdir+test
rtl/mips_pkg.sv
rtl/mips_fetch.sv
rtl/mips_regfile.sv
rtl/mips_decode.sv
rtl/mips_execute.sv
rtl/mips_memwb.sv
rtl/mips_core.sv
test/tb_mips.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_mips
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
